// ==== dcache_pkg.sv ====
// shared definitions for the data cache
//   address split and geometry constants
//   packed request/response structs for the cpu and memory channels
//   controller state encoding

package dcache_pkg;

  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int STRB_W   = DATA_W / 8;
  localparam int OFFSET_W = 3;                           // byte within word
  localparam int INDEX_W  = 6;
  localparam int SETS     = 1 << INDEX_W;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 23 bits
  localparam int WAYS     = 2;

  // peripheral space sits below this boundary
  localparam logic [ADDR_W-1:0] UNCACHED_LIMIT = 32'h8000_0000;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } cpu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [1:0]        resp;
  } cpu_rsp_t;

  // same layout as the cpu request
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [1:0]        resp;
  } mem_rsp_t;

  typedef enum logic [3:0] {
    IDLE, LOOKUP, RESPOND,
    WB_REQ, WB_RSP,
    FILL_REQ, FILL_RSP,
    UC_REQ, UC_RSP
  } cache_state_e;

endpackage

// ==== dcache_data_ram.sv ====
// one way of cache data storage
//   single port, one 64-bit word per set
//   byte write enables, registered read

`timescale 1ns/10ps

module dcache_data_ram import dcache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               en_i,
  input  logic               we_i,
  input  logic [STRB_W-1:0]  be_i,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [DATA_W-1:0]  wdata_i,
  output logic [DATA_W-1:0]  rdata_o
);

  logic [DATA_W-1:0] mem [SETS];

  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (be_i[b]) begin
          mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (en_i && !we_i) begin
      rdata_o <= mem[index_i]; // held until the next read
    end
  end

  // an x index would corrupt or read an arbitrary set
  index_known_a : assert property (
    @(posedge clk) disable iff (rst)
    en_i |-> !$isunknown(index_i)
  );

endmodule

// ==== dcache_tag_array.sv ====
// tag, valid and dirty storage for both ways
//   registered hit compare
//   free-running victim counter, victim latched at lookup
//   single update port for installs and dirty marking

`timescale 1ns/10ps

module dcache_tag_array import dcache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               lookup_i,
  input  logic [INDEX_W-1:0] index_i,
  input  logic [TAG_W-1:0]   tag_i,
  output logic               hit_o,
  output logic               hit_way_o,
  output logic               victim_way_o,
  output logic               victim_dirty_o,
  output logic [TAG_W-1:0]   victim_tag_o,
  input  logic               upd_i,
  input  logic               upd_way_i,
  input  logic [INDEX_W-1:0] upd_index_i,
  input  logic [TAG_W-1:0]   upd_tag_i,
  input  logic               upd_valid_i,
  input  logic               upd_dirty_i
);

  logic [TAG_W-1:0] tag_mem [WAYS][SETS];
  logic [SETS-1:0]  valid_q [WAYS];
  logic [SETS-1:0]  dirty_q [WAYS];
  logic             victim_ctr_q;
  logic [WAYS-1:0]  match;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid_q[w][index_i] && (tag_mem[w][index_i] == tag_i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q        <= '{default: '0};
      dirty_q        <= '{default: '0};
      victim_ctr_q   <= 1'b0;
      hit_o          <= 1'b0;
      hit_way_o      <= 1'b0;
      victim_way_o   <= 1'b0;
      victim_dirty_o <= 1'b0;
    end else begin
      victim_ctr_q <= victim_ctr_q + 1'b1; // pseudo-random replacement
      if (upd_i) begin
        valid_q[upd_way_i][upd_index_i] <= upd_valid_i;
        dirty_q[upd_way_i][upd_index_i] <= upd_dirty_i;
      end
      if (lookup_i) begin
        hit_o          <= |match;
        hit_way_o      <= match[1];
        victim_way_o   <= victim_ctr_q;
        victim_dirty_o <= valid_q[victim_ctr_q][index_i] & dirty_q[victim_ctr_q][index_i];
      end
    end
  end

  // tags themselves need no reset
  always_ff @(posedge clk) begin
    if (upd_i) begin
      tag_mem[upd_way_i][upd_index_i] <= upd_tag_i;
    end
    if (lookup_i) begin
      victim_tag_o <= tag_mem[victim_ctr_q][index_i];
    end
  end

  // a line may live in one way only
  one_hot_hit_a : assert property (
    @(posedge clk) disable iff (rst)
    lookup_i |-> !(&match)
  );

endmodule

// ==== dcache_ctrl.sv ====
// data cache controller
//   FSM for hit, write-back, refill and uncached paths
//   cpu and memory valid/ready channels
//   drives tag lookup/update and both data rams

`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // cpu side
  input  logic               cpu_req_valid_i,
  output logic               cpu_req_ready_o,
  input  cpu_req_t           cpu_req_i,
  output logic               cpu_rsp_valid_o,
  input  logic               cpu_rsp_ready_i,
  output cpu_rsp_t           cpu_rsp_o,
  // memory side
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  output mem_req_t           mem_req_o,
  input  logic               mem_rsp_valid_i,
  output logic               mem_rsp_ready_o,
  input  mem_rsp_t           mem_rsp_i,
  // tag array
  output logic               lookup_o,
  output logic [INDEX_W-1:0] index_o,
  output logic [TAG_W-1:0]   tag_o,
  input  logic               hit_i,
  input  logic               hit_way_i,
  input  logic               victim_way_i,
  input  logic               victim_dirty_i,
  input  logic [TAG_W-1:0]   victim_tag_i,
  output logic               upd_o,
  output logic               upd_way_o,
  output logic [INDEX_W-1:0] upd_index_o,
  output logic [TAG_W-1:0]   upd_tag_o,
  output logic               upd_valid_o,
  output logic               upd_dirty_o,
  // data rams
  output logic [WAYS-1:0]    ram_en_o,
  output logic               ram_we_o,
  output logic [STRB_W-1:0]  ram_be_o,
  output logic [INDEX_W-1:0] ram_index_o,
  output logic [DATA_W-1:0]  ram_wdata_o,
  input  logic [DATA_W-1:0]  ram_rdata0_i,
  input  logic [DATA_W-1:0]  ram_rdata1_i
);

  cache_state_e state_q;
  cpu_req_t     req_q;
  cpu_rsp_t     rsp_q;
  logic         rsp_valid_q;
  logic         req_ready_q;

  logic               accept;
  logic               in_uncached;
  logic [INDEX_W-1:0] req_index;
  logic [TAG_W-1:0]   req_tag;
  logic [DATA_W-1:0]  hit_word;
  logic [DATA_W-1:0]  victim_word;
  logic               mem_req_fire;
  logic               mem_rsp_fire;
  logic               write_hit;
  logic               fill_done;

  assign accept       = cpu_req_valid_i & req_ready_q;
  assign in_uncached  = cpu_req_i.addr < UNCACHED_LIMIT;
  assign req_index    = req_q.addr[OFFSET_W +: INDEX_W];
  assign req_tag      = req_q.addr[ADDR_W-1 -: TAG_W];
  assign hit_word     = hit_way_i ? ram_rdata1_i : ram_rdata0_i;
  assign victim_word  = victim_way_i ? ram_rdata1_i : ram_rdata0_i;
  assign mem_req_fire = mem_req_valid_o & mem_req_ready_i;
  assign mem_rsp_fire = mem_rsp_valid_i & mem_rsp_ready_o;
  assign fill_done    = (state_q == FILL_RSP) & mem_rsp_fire;

  // first RESPOND cycle of a cached write
  assign write_hit = (state_q == RESPOND) & ~rsp_valid_q & req_q.we;

  assign cpu_req_ready_o = req_ready_q;
  assign cpu_rsp_valid_o = rsp_valid_q;
  assign cpu_rsp_o       = rsp_q;
  assign mem_rsp_ready_o = (state_q == WB_RSP) | (state_q == FILL_RSP) | (state_q == UC_RSP);

  // lookup on accept, and again once the fill lands
  assign lookup_o = (accept & ~in_uncached) | fill_done;
  assign index_o  = (state_q == IDLE) ? cpu_req_i.addr[OFFSET_W +: INDEX_W] : req_index;
  assign tag_o    = (state_q == IDLE) ? cpu_req_i.addr[ADDR_W-1 -: TAG_W] : req_tag;

  always_comb begin
    upd_o       = 1'b0;
    upd_way_o   = hit_way_i;
    upd_index_o = req_index;
    upd_tag_o   = req_tag;
    upd_valid_o = 1'b1;
    upd_dirty_o = 1'b0;
    if ((state_q == FILL_REQ) && mem_req_fire) begin
      upd_o     = 1'b1;          // install clean, ready for re-lookup
      upd_way_o = victim_way_i;
    end else if (write_hit) begin
      upd_o       = 1'b1;
      upd_dirty_o = 1'b1;
    end
  end

  always_comb begin
    ram_en_o    = '0;
    ram_we_o    = 1'b0;
    ram_be_o    = '1;
    ram_index_o = req_index;
    ram_wdata_o = mem_rsp_i.rdata;
    if (state_q == LOOKUP) begin
      if (hit_i) begin
        ram_en_o[hit_way_i] = 1'b1;
      end else if (victim_dirty_i) begin
        ram_en_o[victim_way_i] = 1'b1; // victim word for write-back
      end
    end else if (fill_done) begin
      ram_en_o[victim_way_i] = 1'b1;
      ram_we_o               = 1'b1;
    end else if (write_hit) begin
      ram_en_o[hit_way_i] = 1'b1;
      ram_we_o            = 1'b1;
      ram_be_o            = req_q.wstrb;
      ram_wdata_o         = req_q.wdata;
    end
  end

  always_comb begin
    mem_req_valid_o = 1'b0;
    mem_req_o       = '0;
    case (state_q)
      WB_REQ: begin
        mem_req_valid_o = 1'b1;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = {victim_tag_i, req_index, {OFFSET_W{1'b0}}};
        mem_req_o.wdata = victim_word;
        mem_req_o.wstrb = '1;
      end
      FILL_REQ: begin
        mem_req_valid_o = 1'b1;
        mem_req_o.addr  = {req_tag, req_index, {OFFSET_W{1'b0}}};
        mem_req_o.wstrb = '1;
      end
      UC_REQ: begin
        mem_req_valid_o = 1'b1;
        mem_req_o       = mem_req_t'(req_q); // passed through untouched
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
      req_ready_q <= 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            req_ready_q <= 1'b0;
            state_q     <= in_uncached ? UC_REQ : LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit_i) begin
            state_q <= RESPOND;
          end else if (victim_dirty_i) begin
            state_q <= WB_REQ;
          end else begin
            state_q <= FILL_REQ;
          end
        end
        WB_REQ:   if (mem_req_fire) state_q <= WB_RSP;
        WB_RSP:   if (mem_rsp_fire) state_q <= FILL_REQ;
        FILL_REQ: if (mem_req_fire) state_q <= FILL_RSP;
        FILL_RSP: if (mem_rsp_fire) state_q <= LOOKUP;
        UC_REQ:   if (mem_req_fire) state_q <= UC_RSP;
        UC_RSP: begin
          if (mem_rsp_fire) begin
            rsp_valid_q <= 1'b1;
            state_q     <= RESPOND;
          end
        end
        RESPOND: begin
          if (!rsp_valid_q) begin
            rsp_valid_q <= 1'b1;
          end else if (cpu_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
            req_ready_q <= 1'b1;
            state_q     <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= cpu_req_i;
    end
    if ((state_q == RESPOND) && !rsp_valid_q) begin
      rsp_q.rdata <= req_q.we ? '0 : hit_word;
      rsp_q.resp  <= 2'b00;
    end else if ((state_q == UC_RSP) && mem_rsp_fire) begin
      rsp_q <= cpu_rsp_t'(mem_rsp_i); // resp forwarded as is
    end
  end

  mem_req_stable_a : assert property (
    @(posedge clk) disable iff (rst)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  );

  // one request in flight
  req_ready_idle_a : assert property (
    @(posedge clk) disable iff (rst)
    cpu_req_ready_o |-> state_q == IDLE
  );

endmodule

// ==== dcache_top.sv ====
// data cache top level
//   controller, tag array and one data ram per way

`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     cpu_req_valid_i,
  output logic     cpu_req_ready_o,
  input  cpu_req_t cpu_req_i,
  output logic     cpu_rsp_valid_o,
  input  logic     cpu_rsp_ready_i,
  output cpu_rsp_t cpu_rsp_o,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  output mem_req_t mem_req_o,
  input  logic     mem_rsp_valid_i,
  output logic     mem_rsp_ready_o,
  input  mem_rsp_t mem_rsp_i
);

  logic               lookup;
  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0]   lookup_tag;
  logic               hit;
  logic               hit_way;
  logic               victim_way;
  logic               victim_dirty;
  logic [TAG_W-1:0]   victim_tag;
  logic               upd;
  logic               upd_way;
  logic [INDEX_W-1:0] upd_index;
  logic [TAG_W-1:0]   upd_tag;
  logic               upd_valid;
  logic               upd_dirty;
  logic [WAYS-1:0]    ram_en;
  logic               ram_we;
  logic [STRB_W-1:0]  ram_be;
  logic [INDEX_W-1:0] ram_index;
  logic [DATA_W-1:0]  ram_wdata;
  logic [DATA_W-1:0]  ram_rdata0;
  logic [DATA_W-1:0]  ram_rdata1;

  dcache_ctrl dcache_ctrl_inst (
    .clk, .rst,
    .cpu_req_valid_i, .cpu_req_ready_o, .cpu_req_i,
    .cpu_rsp_valid_o, .cpu_rsp_ready_i, .cpu_rsp_o,
    .mem_req_valid_o, .mem_req_ready_i, .mem_req_o,
    .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_i,
    .lookup_o(lookup), .index_o(lookup_index), .tag_o(lookup_tag),
    .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
    .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
    .upd_o(upd), .upd_way_o(upd_way), .upd_index_o(upd_index), .upd_tag_o(upd_tag),
    .upd_valid_o(upd_valid), .upd_dirty_o(upd_dirty),
    .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_be_o(ram_be),
    .ram_index_o(ram_index), .ram_wdata_o(ram_wdata),
    .ram_rdata0_i(ram_rdata0), .ram_rdata1_i(ram_rdata1)
  );

  dcache_tag_array dcache_tag_array_inst (
    .clk, .rst,
    .lookup_i(lookup), .index_i(lookup_index), .tag_i(lookup_tag),
    .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
    .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag),
    .upd_i(upd), .upd_way_i(upd_way), .upd_index_i(upd_index), .upd_tag_i(upd_tag),
    .upd_valid_i(upd_valid), .upd_dirty_i(upd_dirty)
  );

  dcache_data_ram dcache_data_ram0_inst ( // way 0
    .clk, .rst, .en_i(ram_en[0]), .we_i(ram_we), .be_i(ram_be),
    .index_i(ram_index), .wdata_i(ram_wdata), .rdata_o(ram_rdata0)
  );

  dcache_data_ram dcache_data_ram1_inst ( // way 1
    .clk, .rst, .en_i(ram_en[1]), .we_i(ram_we), .be_i(ram_be),
    .index_i(ram_index), .wdata_i(ram_wdata), .rdata_o(ram_rdata1)
  );

endmodule

// ==== dcache_checker.sv ====
// response checker for the data cache
//   shadow memory updated by cpu writes with strobes
//   read data, response code, write-back data and uncached forwarding checks
//   response hold, ready and repeated-access latency checks

`timescale 1ns/10ps

module dcache_checker import dcache_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     cpu_req_valid_i,
  input  logic     cpu_req_ready_i,
  input  cpu_req_t cpu_req_i,
  input  logic     cpu_rsp_valid_i,
  input  logic     cpu_rsp_ready_i,
  input  cpu_rsp_t cpu_rsp_i,
  input  logic     mem_req_valid_i,
  input  logic     mem_req_ready_i,
  input  mem_req_t mem_req_i,
  input  logic     mem_rsp_ready_i,
  output int       errors_o,
  output int       checks_o,
  output int       responses_o
);

  logic [DATA_W-1:0] shadow [512];
  logic [511:0]      touched = '0;
  cpu_req_t          cur_req;
  cpu_rsp_t          held_rsp;
  logic [DATA_W-1:0] expected_rdata;
  logic [ADDR_W-1:0] last_addr;
  logic              last_valid;
  logic              in_flight;
  logic              uc_pending;
  logic              hold;
  logic              rsp_valid_prev;
  logic              reset_seen;
  logic              fast_expected;
  int                cycle_no;
  int                accept_cycle;
  int                errors    = 0;
  int                checks    = 0;
  int                responses = 0;

  assign errors_o    = errors;
  assign checks_o    = checks;
  assign responses_o = responses;

  function automatic int word_slot(input logic [ADDR_W-1:0] addr);
    return {addr[31], addr[10:3]};
  endfunction

  // same per-word fill as the memory model
  function automatic logic [DATA_W-1:0] pattern_word(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] w;
    w = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    return {w ^ 32'hc3a5_0f96, ~w};
  endfunction

  task automatic touch_word(input logic [ADDR_W-1:0] addr);
    if (!touched[word_slot(addr)]) begin
      shadow[word_slot(addr)]  = pattern_word(addr);
      touched[word_slot(addr)] = 1'b1;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      in_flight      = 1'b0;
      uc_pending     = 1'b0;
      hold           = 1'b0;
      rsp_valid_prev = 1'b0;
      reset_seen     = 1'b0;
      last_valid     = 1'b0;
      fast_expected  = 1'b0;
      cycle_no       = 0;
    end else begin
      cycle_no++;
      if (!reset_seen) begin
        reset_seen = 1'b1;
        checks++;
        if (!cpu_req_ready_i || cpu_rsp_valid_i || mem_req_valid_i || mem_rsp_ready_i)
          report_problem("handshake outputs not at their reset values after reset");
      end
      if (hold) begin // response was stalled last edge
        checks++;
        if (!cpu_rsp_valid_i)
          report_problem("cpu_rsp_valid_o dropped before the response was taken");
        else if (cpu_rsp_i !== held_rsp)
          report_mismatch("cpu_rsp_o", cpu_rsp_i, held_rsp);
      end
      hold     = cpu_rsp_valid_i && !cpu_rsp_ready_i;
      held_rsp = cpu_rsp_i;
      if (in_flight && cpu_req_ready_i)
        report_problem("cpu_req_ready_o high while a request is in flight");
      if (cpu_rsp_valid_i && !rsp_valid_prev && in_flight && fast_expected) begin
        checks++;
        // valid rose on the previous edge
        if (cycle_no - 1 - accept_cycle != 2)
          report_problem($sformatf("repeated access to %h answered %0d cycles after accept",
                                   cur_req.addr, cycle_no - 1 - accept_cycle));
      end
      rsp_valid_prev = cpu_rsp_valid_i;
      if (cpu_rsp_valid_i && cpu_rsp_ready_i) begin
        if (!in_flight) begin
          report_problem("cpu response with no request in flight");
        end else begin
          if (!cur_req.we) begin
            checks++;
            if (cpu_rsp_i.rdata !== expected_rdata)
              report_mismatch("cpu_rsp_o.rdata", cpu_rsp_i.rdata, expected_rdata);
          end
          // memory model always answers okay
          checks++;
          if (cpu_rsp_i.resp !== 2'b00)
            report_mismatch("cpu_rsp_o.resp", cpu_rsp_i.resp, 2'b00);
          if (uc_pending) report_problem("uncached request completed without a memory request");
          responses++;
          last_addr  = cur_req.addr;
          last_valid = 1'b1;
        end
        in_flight  = 1'b0;
        uc_pending = 1'b0;
      end
      if (mem_req_valid_i && mem_req_ready_i) begin
        checks++;
        if (mem_req_i.addr < UNCACHED_LIMIT) begin
          if (!uc_pending)
            report_problem("memory request to uncached space without an uncached cpu request");
          else if (mem_req_i !== mem_req_t'(cur_req))
            report_mismatch("mem_req_o", mem_req_i, cur_req);
          uc_pending = 1'b0;
        end else begin
          if (mem_req_i.addr[OFFSET_W-1:0] != '0)
            report_problem("cacheable memory request not word aligned");
          if (mem_req_i.we) begin // dirty write-back
            touch_word(mem_req_i.addr);
            if (mem_req_i.wstrb !== '1)
              report_mismatch("mem_req_o.wstrb", mem_req_i.wstrb, 8'hff);
            if (mem_req_i.wdata !== shadow[word_slot(mem_req_i.addr)])
              report_mismatch("mem_req_o.wdata", mem_req_i.wdata,
                              shadow[word_slot(mem_req_i.addr)]);
          end
        end
      end
      if (cpu_req_valid_i && cpu_req_ready_i) begin
        cur_req       = cpu_req_i;
        in_flight     = 1'b1;
        accept_cycle  = cycle_no;
        uc_pending    = cpu_req_i.addr < UNCACHED_LIMIT;
        fast_expected = last_valid && !uc_pending &&
                        (cpu_req_i.addr[ADDR_W-1:OFFSET_W] == last_addr[ADDR_W-1:OFFSET_W]);
        touch_word(cpu_req_i.addr);
        if (cpu_req_i.we) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (cpu_req_i.wstrb[b])
              shadow[word_slot(cpu_req_i.addr)][8*b +: 8] = cpu_req_i.wdata[8*b +: 8];
          end
        end
        expected_rdata = shadow[word_slot(cpu_req_i.addr)];
      end
    end
  end

endmodule

// ==== dcache_tb.sv ====
// testbench top for the data cache
//   clock, reset and DUT instance
//   xorshift request stimulus with response back-pressure
//   memory responder with random latency and a backing store
//   run timeout and closing summary

`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

  localparam int NUM_REQS       = 400;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 60 + 100;
  localparam logic [31:0] SEED  = 32'd19;

  logic     clk             = 1'b0;
  logic     rst             = 1'b1;
  logic     cpu_req_valid_i = 1'b0;
  cpu_req_t cpu_req_i       = '0;
  logic     cpu_rsp_ready_i = 1'b0;
  logic     mem_req_ready_i = 1'b0;
  logic     mem_rsp_valid_i = 1'b0;
  mem_rsp_t mem_rsp_i       = '0;
  logic     cpu_req_ready_o;
  logic     cpu_rsp_valid_o;
  cpu_rsp_t cpu_rsp_o;
  logic     mem_req_valid_o;
  mem_req_t mem_req_o;
  logic     mem_rsp_ready_o;

  int errors;
  int checks;
  int responses;
  int cycle_count = 0;

  // three streams derived from the one seed
  logic [31:0] stim_rng  = SEED;
  logic [31:0] ready_rng = SEED ^ 32'h2545_f491;
  logic [31:0] mem_rng   = SEED ^ 32'h9e37_79b9;

  logic [DATA_W-1:0] store [512]; // backing store
  logic [511:0]      touched = '0;
  logic              mem_busy = 1'b0;
  int                mem_delay = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // pool addresses differ only in bit 31 and bits 10:3
  function automatic int word_slot(input logic [ADDR_W-1:0] addr);
    return {addr[31], addr[10:3]};
  endfunction

  function automatic logic [DATA_W-1:0] pattern_word(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] w;
    w = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    return {w ^ 32'hc3a5_0f96, ~w};
  endfunction

  always #2 clk = ~clk;

  dcache_top dcache_top_inst (
    .clk, .rst,
    .cpu_req_valid_i, .cpu_req_ready_o, .cpu_req_i,
    .cpu_rsp_valid_o, .cpu_rsp_ready_i, .cpu_rsp_o,
    .mem_req_valid_o, .mem_req_ready_i, .mem_req_o,
    .mem_rsp_valid_i, .mem_rsp_ready_o, .mem_rsp_i
  );

  dcache_checker checker_inst (
    .clk, .rst,
    .cpu_req_valid_i(cpu_req_valid_i), .cpu_req_ready_i(cpu_req_ready_o),
    .cpu_req_i(cpu_req_i),
    .cpu_rsp_valid_i(cpu_rsp_valid_o), .cpu_rsp_ready_i(cpu_rsp_ready_i),
    .cpu_rsp_i(cpu_rsp_o),
    .mem_req_valid_i(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
    .mem_req_i(mem_req_o), .mem_rsp_ready_i(mem_rsp_ready_o),
    .errors_o(errors), .checks_o(checks), .responses_o(responses)
  );

  initial begin : stimulus
    logic [31:0]       r1;
    logic [31:0]       r2;
    logic [31:0]       r3;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] last_addr;
    cpu_req_t          req;
    last_addr = UNCACHED_LIMIT;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < NUM_REQS; n++) begin
      stim_rng = xorshift32(stim_rng);
      r1 = stim_rng;
      stim_rng = xorshift32(stim_rng);
      r2 = stim_rng;
      stim_rng = xorshift32(stim_rng);
      r3 = stim_rng;
      if (r1[25:23] == 3'd0) begin
        addr = last_addr;          // same word again
      end else if (r1[4:2] == 3'd0) begin
        addr = 32'h1000_0000;      // peripheral space
        addr[4:3] = r1[6:5];
      end else begin
        addr = UNCACHED_LIMIT;
        addr[10:9] = r1[8:7];      // tag
        addr[4:3]  = r1[10:9];     // index
      end
      addr[2:0] = r1[13:11];
      last_addr = addr;
      req.we    = r1[14];
      req.addr  = addr;
      req.wdata = {r2, r3};
      req.wstrb = r1[22:15];
      cpu_req_valid_i <= 1'b1;
      cpu_req_i       <= req;
      @(posedge clk);
      while (!cpu_req_ready_o) @(posedge clk);
    end
    cpu_req_valid_i <= 1'b0;
    while (responses < NUM_REQS) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d, responses %0d", checks, errors, responses);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    ready_rng = xorshift32(ready_rng);
    cpu_rsp_ready_i <= !rst && (ready_rng[1:0] != 2'd0); // stall about one cycle in four
  end

  always @(posedge clk) begin : mem_responder
    int s;
    if (rst) begin
      mem_req_ready_i <= 1'b0;
      mem_rsp_valid_i <= 1'b0;
      mem_busy = 1'b0;
    end else if (!mem_busy) begin
      mem_req_ready_i <= 1'b1;
      if (mem_req_valid_o && mem_req_ready_i) begin
        mem_busy = 1'b1;
        mem_req_ready_i <= 1'b0;
        mem_rng = xorshift32(mem_rng);
        mem_delay = 1 + int'(mem_rng % 6);
        s = word_slot(mem_req_o.addr);
        if (!touched[s]) begin
          store[s]   = pattern_word(mem_req_o.addr);
          touched[s] = 1'b1;
        end
        if (mem_req_o.we) begin
          for (int b = 0; b < STRB_W; b++) begin
            if (mem_req_o.wstrb[b]) store[s][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
          end
        end
        mem_rsp_i.rdata <= mem_req_o.we ? '0 : store[s];
        mem_rsp_i.resp  <= 2'b00;
      end
    end else if (!mem_rsp_valid_i) begin
      mem_delay = mem_delay - 1;
      if (mem_delay == 0) mem_rsp_valid_i <= 1'b1;
    end else if (mem_rsp_ready_o) begin
      mem_rsp_valid_i <= 1'b0;
      mem_req_ready_i <= 1'b1;
      mem_busy = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, checks %0d, errors %0d, responses %0d of %0d",
               cycle_count, checks, errors, responses, NUM_REQS);
      $display("Regression failed");
      $finish;
    end
  end

endmodule

// ==== dcache.f ====
dcache_pkg.sv
dcache_data_ram.sv
dcache_tag_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
dcache_tb.sv
